/* verilog/udp_ctrl_pkg.sv */
// ====================
// Shared address and length types
// Header byte offsets and protocol constants
// ====================
package udp_ctrl_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] len16_t;

    // Ethernet 14, IPv4 20 and UDP 8 bytes ahead of the payload
    localparam logic [5:0] HDR_BYTES = 6'd42;

    // Byte offsets within the header
    localparam logic [5:0] OFS_DST_MAC = 6'd0;
    localparam logic [5:0] OFS_SRC_MAC = 6'd6;
    localparam logic [5:0] OFS_ETHERTYPE = 6'd12;
    localparam logic [5:0] OFS_IP_VER_IHL = 6'd14;
    localparam logic [5:0] OFS_IP_PROTO = 6'd23;
    localparam logic [5:0] OFS_SRC_IP = 6'd26;
    localparam logic [5:0] OFS_DST_IP = 6'd30;
    localparam logic [5:0] OFS_SRC_PORT = 6'd34;
    localparam logic [5:0] OFS_DST_PORT = 6'd36;
    localparam logic [5:0] OFS_UDP_LEN = 6'd38;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    // Version 4 with a 5-word header, no options
    localparam logic [7:0] IP_VER_IHL = 8'h45;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;
    localparam logic [7:0] IP_TTL = 8'd64;
    localparam len16_t IP_HDR_BYTES = 16'd20;
    localparam len16_t UDP_HDR_BYTES = 16'd8;
    localparam mac_addr_t MAC_BROADCAST = '1;

endpackage

/* verilog/udp_rx_parser.sv */
// ====================
// Receive parser for Ethernet/IPv4/UDP requests
// Frame filter, payload trimming, reply address capture
// ====================
`timescale 1ns/1ps

module udp_rx_parser import udp_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] eth_in_data,
    input  logic       eth_in_valid,
    output logic       eth_in_ready,
    input  logic       eth_in_last,
    input  logic       eth_in_user,
    input  mac_addr_t  local_mac,
    input  ip_addr_t   local_ip,
    input  udp_port_t  local_port,
    output logic [7:0] pay_data,
    output logic       pay_valid,
    input  logic       pay_ready,
    output logic       pay_last,
    output logic       pay_user,
    output mac_addr_t  reply_mac,
    output ip_addr_t   reply_ip,
    output udp_port_t  reply_port
);

    typedef enum logic [1:0] {ST_HDR, ST_PAY, ST_DROP} state_t;

    state_t      state;
    logic [5:0]  hdr_cnt;
    logic [39:0] hdr_shift;
    logic [47:0] word;
    logic        match;
    logic        field_ok;
    logic        cnt_done;
    mac_addr_t   src_mac_tmp;
    ip_addr_t    src_ip_tmp;
    udp_port_t   src_port_tmp;
    len16_t      pay_len;
    len16_t      pay_cnt;

    // Current byte appended to the previous five
    assign word = {hdr_shift, eth_in_data};
    assign cnt_done = (pay_cnt + 16'd1 == pay_len);

    assign eth_in_ready = (state == ST_PAY) ? pay_ready : 1'b1;
    assign pay_data = eth_in_data;
    assign pay_valid = (state == ST_PAY) && eth_in_valid;
    assign pay_last = cnt_done || eth_in_last;
    // Frame ends before the UDP length is reached
    assign pay_user = eth_in_last && (eth_in_user || !cnt_done);

    // Each field is checked on its final byte
    always_comb begin
        case (hdr_cnt)
            OFS_DST_MAC + 6'd5:    field_ok = (word == local_mac) || (word == MAC_BROADCAST);
            OFS_ETHERTYPE + 6'd1:  field_ok = (word[15:0] == ETHERTYPE_IPV4);
            OFS_IP_VER_IHL:        field_ok = (eth_in_data == IP_VER_IHL);
            OFS_IP_PROTO:          field_ok = (eth_in_data == IP_PROTO_UDP);
            OFS_DST_IP + 6'd3:     field_ok = (word[31:0] == local_ip);
            OFS_DST_PORT + 6'd1:   field_ok = (word[15:0] == local_port);
            default:               field_ok = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_HDR;
            hdr_cnt <= '0;
            match <= 1'b1;
            pay_cnt <= '0;
        end else begin
            case (state)
                ST_HDR: if (eth_in_valid) begin
                    match <= match && field_ok;
                    hdr_cnt <= hdr_cnt + 6'd1;
                    if (eth_in_last) begin
                        // Runt frame, nothing forwarded
                        hdr_cnt <= '0;
                        match <= 1'b1;
                    end else if (hdr_cnt == HDR_BYTES - 6'd1) begin
                        hdr_cnt <= '0;
                        match <= 1'b1;
                        pay_cnt <= '0;
                        state <= (match && pay_len != 16'd0) ? ST_PAY : ST_DROP;
                    end
                end
                ST_PAY: if (eth_in_valid && pay_ready) begin
                    pay_cnt <= pay_cnt + 16'd1;
                    if (eth_in_last) begin
                        state <= ST_HDR;
                    end else if (cnt_done) begin
                        // Ethernet padding follows
                        state <= ST_DROP;
                    end
                end
                default: if (eth_in_valid && eth_in_last) begin
                    state <= ST_HDR;
                end
            endcase
        end
    end

    // Header field capture
    always_ff @(posedge clk) begin
        if (state == ST_HDR && eth_in_valid) begin
            hdr_shift <= word[39:0];
            case (hdr_cnt)
                OFS_SRC_MAC + 6'd5:  src_mac_tmp <= word;
                OFS_SRC_IP + 6'd3:   src_ip_tmp <= word[31:0];
                OFS_SRC_PORT + 6'd1: src_port_tmp <= word[15:0];
                OFS_DST_PORT + 6'd1: if (match && field_ok) begin
                    reply_mac <= src_mac_tmp;
                    reply_ip <= src_ip_tmp;
                    reply_port <= src_port_tmp;
                end
                OFS_UDP_LEN + 6'd1:
                    pay_len <= (word[15:0] > UDP_HDR_BYTES) ? word[15:0] - UDP_HDR_BYTES : 16'd0;
                default: ;
            endcase
        end
    end

endmodule

/* verilog/skid_buffer.sv */
// ====================
// Two-entry register stage with registered ready
// ====================
`timescale 1ns/1ps

module skid_buffer (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       in_last,
    input  logic       in_user,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       out_last,
    output logic       out_user
);

    // Data, last and user kept together
    logic [9:0] out_word;
    logic [9:0] tmp_word;
    logic       tmp_valid;
    logic       out_valid_next;
    logic       tmp_valid_next;
    logic       ready_early;
    logic       store_in_out;
    logic       store_in_tmp;
    logic       store_tmp_out;

    assign {out_data, out_last, out_user} = out_word;

    // Ready next cycle unless the temp entry could fill
    assign ready_early = out_ready || (!tmp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next = out_valid;
        tmp_valid_next = tmp_valid;
        store_in_out = 1'b0;
        store_in_tmp = 1'b0;
        store_tmp_out = 1'b0;
        if (in_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next = in_valid;
                store_in_out = 1'b1;
            end else begin
                tmp_valid_next = in_valid;
                store_in_tmp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            store_tmp_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
            in_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            tmp_valid <= tmp_valid_next;
            in_ready <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_out) begin
            out_word <= {in_data, in_last, in_user};
        end else if (store_tmp_out) begin
            out_word <= tmp_word;
        end
        if (store_in_tmp) begin
            tmp_word <= {in_data, in_last, in_user};
        end
    end

endmodule

/* verilog/reply_fifo.sv */
// ====================
// Single-frame reply buffer
// Reports frame length once the last byte is stored
// ====================
`timescale 1ns/1ps

module reply_fifo import udp_ctrl_pkg::*; #(
    parameter int REPLY_DEPTH = 256
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] down_in_data,
    input  logic       down_in_valid,
    output logic       down_in_ready,
    input  logic       down_in_last,
    input  logic       down_in_user,
    output logic       frame_ready,
    output len16_t     frame_len,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       rd_last,
    output logic       rd_user,
    input  logic       frame_done
);

    localparam int AW = $clog2(REPLY_DEPTH);
    localparam len16_t CAP = len16_t'(REPLY_DEPTH);

    logic [7:0] mem [REPLY_DEPTH];
    len16_t     wr_cnt;
    len16_t     rd_ptr;
    logic       frame_err;
    logic       wr_fire;
    logic       has_room;
    logic       rd_at_end;

    // Closed while a complete frame waits for the framer
    assign down_in_ready = !frame_ready;
    assign wr_fire = down_in_valid && down_in_ready;
    assign has_room = (wr_cnt < CAP);
    assign frame_len = wr_cnt;
    assign rd_at_end = (rd_ptr + 16'd1 == wr_cnt);

    always_ff @(posedge clk) begin
        if (wr_fire && has_room) begin
            mem[wr_cnt[AW-1:0]] <= down_in_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr[AW-1:0]];
            rd_last <= rd_at_end;
            rd_user <= rd_at_end && frame_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || frame_done) begin
            wr_cnt <= '0;
            rd_ptr <= '0;
            frame_ready <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (wr_fire) begin
                if (has_room) begin
                    wr_cnt <= wr_cnt + 16'd1;
                end
                // Truncated or flagged frames end with user set
                if (!has_room || (down_in_last && down_in_user)) begin
                    frame_err <= 1'b1;
                end
                if (down_in_last) begin
                    frame_ready <= 1'b1;
                end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 16'd1;
            end
        end
    end

endmodule

/* verilog/udp_tx_framer.sv */
// ====================
// Reply frame builder
// Header with IP checksum, then buffered payload
// ====================
`timescale 1ns/1ps

module udp_tx_framer import udp_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       frame_ready,
    input  len16_t     frame_len,
    output logic       rd_en,
    input  logic [7:0] rd_data,
    input  logic       rd_last,
    input  logic       rd_user,
    output logic       frame_done,
    input  mac_addr_t  reply_mac,
    input  ip_addr_t   reply_ip,
    input  udp_port_t  reply_port,
    input  mac_addr_t  local_mac,
    input  ip_addr_t   local_ip,
    input  udp_port_t  local_port,
    output logic [7:0] eth_out_data,
    output logic       eth_out_valid,
    input  logic       eth_out_ready,
    output logic       eth_out_last,
    output logic       eth_out_user
);

    localparam int HDR_W = 8 * int'(HDR_BYTES);

    typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PAY} state_t;

    state_t           state;
    logic [5:0]       hdr_cnt;
    logic [HDR_W-1:0] hdr_sr;
    logic [HDR_W-1:0] hdr_vec;
    len16_t           ip_len;
    len16_t           udp_len;
    logic [19:0]      csum_acc;
    logic [15:0]      csum;
    logic             start;

    assign ip_len = frame_len + IP_HDR_BYTES + UDP_HDR_BYTES;
    assign udp_len = frame_len + UDP_HDR_BYTES;

    // Ones-complement sum of the IP header, zero words left out
    always_comb begin
        csum_acc = {IP_VER_IHL, 8'h00} + ip_len + {IP_TTL, IP_PROTO_UDP}
                 + local_ip[31:16] + local_ip[15:0] + reply_ip[31:16] + reply_ip[15:0];
        csum_acc = {4'h0, csum_acc[15:0]} + {16'h0, csum_acc[19:16]};
        csum_acc = {4'h0, csum_acc[15:0]} + {16'h0, csum_acc[19:16]};
        csum = ~csum_acc[15:0];
    end

    // Identification, flags, fragment offset and UDP checksum are zero
    assign hdr_vec = {reply_mac, local_mac, ETHERTYPE_IPV4,
                      IP_VER_IHL, 8'h00, ip_len, 16'h0000, 16'h0000,
                      IP_TTL, IP_PROTO_UDP, csum, local_ip, reply_ip,
                      local_port, reply_port, udp_len, 16'h0000};

    assign start = (state == ST_IDLE) && frame_ready;
    // First byte fetched at start, then one byte ahead of the output
    assign rd_en = start || (state == ST_PAY && eth_out_ready && !rd_last);
    assign frame_done = (state == ST_PAY) && eth_out_ready && rd_last;

    assign eth_out_valid = (state != ST_IDLE);
    assign eth_out_data = (state == ST_PAY) ? rd_data : hdr_sr[HDR_W-1 -: 8];
    assign eth_out_last = (state == ST_PAY) && rd_last;
    assign eth_out_user = (state == ST_PAY) && rd_user;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            hdr_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: if (frame_ready) begin
                    state <= ST_HDR;
                    hdr_cnt <= '0;
                end
                ST_HDR: if (eth_out_ready) begin
                    hdr_cnt <= hdr_cnt + 6'd1;
                    if (hdr_cnt == HDR_BYTES - 6'd1) begin
                        state <= ST_PAY;
                    end
                end
                default: if (frame_done) begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Header shifts out most significant byte first
    always_ff @(posedge clk) begin
        if (start) begin
            hdr_sr <= hdr_vec;
        end else if (state == ST_HDR && eth_out_ready) begin
            hdr_sr <= {hdr_sr[HDR_W-9:0], 8'h00};
        end
    end

endmodule

/* verilog/udp_ctrl_interface.sv */
// ====================
// UDP control endpoint top level
// Receive parser, output stage, reply buffer, framer
// ====================
`timescale 1ns/1ps

module udp_ctrl_interface import udp_ctrl_pkg::*; #(
    parameter int REPLY_DEPTH = 256
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] eth_in_data,
    input  logic       eth_in_valid,
    output logic       eth_in_ready,
    input  logic       eth_in_last,
    input  logic       eth_in_user,
    output logic [7:0] eth_out_data,
    output logic       eth_out_valid,
    input  logic       eth_out_ready,
    output logic       eth_out_last,
    output logic       eth_out_user,
    output logic [7:0] down_out_data,
    output logic       down_out_valid,
    input  logic       down_out_ready,
    output logic       down_out_last,
    output logic       down_out_user,
    input  logic [7:0] down_in_data,
    input  logic       down_in_valid,
    output logic       down_in_ready,
    input  logic       down_in_last,
    input  logic       down_in_user,
    input  mac_addr_t  local_mac,
    input  ip_addr_t   local_ip,
    input  udp_port_t  local_port
);

    // Request payload into the output stage
    logic [7:0] pay_data;
    logic       pay_valid;
    logic       pay_ready;
    logic       pay_last;
    logic       pay_user;

    mac_addr_t  reply_mac;
    ip_addr_t   reply_ip;
    udp_port_t  reply_port;

    // Reply buffer to framer
    logic       frame_ready;
    len16_t     frame_len;
    logic       rd_en;
    logic [7:0] rd_data;
    logic       rd_last;
    logic       rd_user;
    logic       frame_done;

    udp_rx_parser rx_parser (
        .clk(clk), .rst(rst),
        .eth_in_data(eth_in_data), .eth_in_valid(eth_in_valid),
        .eth_in_ready(eth_in_ready), .eth_in_last(eth_in_last),
        .eth_in_user(eth_in_user),
        .local_mac(local_mac), .local_ip(local_ip), .local_port(local_port),
        .pay_data(pay_data), .pay_valid(pay_valid), .pay_ready(pay_ready),
        .pay_last(pay_last), .pay_user(pay_user),
        .reply_mac(reply_mac), .reply_ip(reply_ip), .reply_port(reply_port)
    );

    skid_buffer down_stage (
        .clk(clk), .rst(rst),
        .in_data(pay_data), .in_valid(pay_valid), .in_ready(pay_ready),
        .in_last(pay_last), .in_user(pay_user),
        .out_data(down_out_data), .out_valid(down_out_valid),
        .out_ready(down_out_ready), .out_last(down_out_last),
        .out_user(down_out_user)
    );

    reply_fifo #(
        .REPLY_DEPTH(REPLY_DEPTH)
    ) reply_buf (
        .clk(clk), .rst(rst),
        .down_in_data(down_in_data), .down_in_valid(down_in_valid),
        .down_in_ready(down_in_ready), .down_in_last(down_in_last),
        .down_in_user(down_in_user),
        .frame_ready(frame_ready), .frame_len(frame_len),
        .rd_en(rd_en), .rd_data(rd_data), .rd_last(rd_last), .rd_user(rd_user),
        .frame_done(frame_done)
    );

    udp_tx_framer tx_framer (
        .clk(clk), .rst(rst),
        .frame_ready(frame_ready), .frame_len(frame_len),
        .rd_en(rd_en), .rd_data(rd_data), .rd_last(rd_last), .rd_user(rd_user),
        .frame_done(frame_done),
        .reply_mac(reply_mac), .reply_ip(reply_ip), .reply_port(reply_port),
        .local_mac(local_mac), .local_ip(local_ip), .local_port(local_port),
        .eth_out_data(eth_out_data), .eth_out_valid(eth_out_valid),
        .eth_out_ready(eth_out_ready), .eth_out_last(eth_out_last),
        .eth_out_user(eth_out_user)
    );

endmodule

/* bench/tb_udp_ctrl_interface.sv */
// ====================
// Testbench for the UDP control endpoint
// Request and reply reference frames, monitors, comparator, watchdog
// ====================
`timescale 1ns/1ps

module tb_udp_ctrl_interface import udp_ctrl_pkg::*; ();

    typedef logic [7:0] bq_t [$];

    // Up to about 20 frames of at most 110 bytes
    localparam int FRAME_BYTES = 20 * 110;
    localparam int TIMEOUT_CYCLES = FRAME_BYTES * 40 + 2000;

    localparam mac_addr_t MY_MAC = 48'h02_00_00_00_00_10;
    localparam ip_addr_t MY_IP = 32'h0a00_0002;
    localparam udp_port_t MY_PORT = 16'h1234;

    logic clk;
    logic rst;
    logic [7:0] eth_in_data, eth_out_data, down_out_data, down_in_data;
    logic eth_in_valid, eth_in_ready, eth_in_last, eth_in_user;
    logic eth_out_valid, eth_out_ready, eth_out_last, eth_out_user;
    logic down_out_valid, down_out_ready, down_out_last, down_out_user;
    logic down_in_valid, down_in_ready, down_in_last, down_in_user;
    mac_addr_t local_mac;
    ip_addr_t local_ip;
    udp_port_t local_port;

    // Words are {data, last, user}
    logic [9:0] exp_down[$], got_down[$], exp_eth[$], got_eth[$];
    int errors;
    int checks;
    logic ready_gaps;
    string test_name;

    udp_ctrl_interface #(.REPLY_DEPTH(256)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Header vector with a zero checksum, sent most significant byte first
    function automatic bq_t put_header(mac_addr_t dst_mac, mac_addr_t src_mac,
            logic [15:0] etype, ip_addr_t src_ip, ip_addr_t dst_ip,
            udp_port_t src_port, udp_port_t dst_port, len16_t udp_len);
        logic [335:0] hdr;
        bq_t q;
        hdr = {dst_mac, src_mac, etype, 8'h45, 8'h00, udp_len + 16'd20, 32'h0,
               8'd64, 8'd17, 16'h0, src_ip, dst_ip, src_port, dst_port, udp_len, 16'h0};
        for (int i = 41; i >= 0; i--) begin
            q.push_back(hdr[8*i +: 8]);
        end
        return q;
    endfunction

    function automatic bq_t build_request(mac_addr_t dst_mac, logic [15:0] etype,
            ip_addr_t dst_ip, udp_port_t dst_port, mac_addr_t src_mac, ip_addr_t src_ip,
            udp_port_t src_port, bq_t pay, len16_t udp_len, int pad);
        bq_t q;
        q = put_header(dst_mac, src_mac, etype, src_ip, dst_ip, src_port, dst_port, udp_len);
        foreach (pay[i]) q.push_back(pay[i]);
        for (int i = 0; i < pad; i++) q.push_back(8'h00);
        return q;
    endfunction

    function automatic bq_t build_reply(mac_addr_t dst_mac, ip_addr_t dst_ip,
            udp_port_t dst_port, bq_t pay);
        bq_t q;
        logic [31:0] sum;
        q = put_header(dst_mac, MY_MAC, 16'h0800, MY_IP, dst_ip, MY_PORT, dst_port,
                       16'(pay.size() + 8));
        sum = 0;
        // IP header is bytes 14 to 33, checksum at 24
        for (int i = 14; i < 34; i += 2) sum += {q[i], q[i+1]};
        sum = sum[15:0] + sum[31:16];
        sum = sum[15:0] + sum[31:16];
        q[24] = ~sum[15:8];
        q[25] = ~sum[7:0];
        foreach (pay[i]) q.push_back(pay[i]);
        return q;
    endfunction

    function automatic bq_t random_payload(int n);
        bq_t q;
        for (int i = 0; i < n; i++) q.push_back(8'($urandom));
        return q;
    endfunction

    task automatic send_eth(bq_t frame);
        for (int i = 0; i < frame.size(); i++) begin
            eth_in_data <= frame[i];
            eth_in_valid <= 1'b1;
            eth_in_last <= (i == frame.size() - 1);
            @(posedge clk);
            while (!eth_in_ready) @(posedge clk);
        end
        eth_in_valid <= 1'b0;
        eth_in_last <= 1'b0;
    endtask

    task automatic send_down(bq_t pay);
        for (int i = 0; i < pay.size(); i++) begin
            down_in_data <= pay[i];
            down_in_valid <= 1'b1;
            down_in_last <= (i == pay.size() - 1);
            @(posedge clk);
            while (!down_in_ready) @(posedge clk);
        end
        down_in_valid <= 1'b0;
        down_in_last <= 1'b0;
    endtask

    // Accepted request whose payload is expected on down_out
    task automatic good_request(mac_addr_t dst_mac, mac_addr_t src_mac, ip_addr_t src_ip,
            udp_port_t src_port, int n);
        bq_t pay;
        pay = random_payload(n);
        foreach (pay[i]) exp_down.push_back({pay[i], i == n - 1, 1'b0});
        send_eth(build_request(dst_mac, 16'h0800, MY_IP, MY_PORT, src_mac, src_ip,
                               src_port, pay, 16'(n + 8), 0));
    endtask

    task automatic reply_check(mac_addr_t mac, ip_addr_t ip, udp_port_t port);
        bq_t pay;
        bq_t frame;
        pay = random_payload(1 + $urandom_range(59));
        frame = build_reply(mac, ip, port, pay);
        foreach (frame[i]) exp_eth.push_back({frame[i], i == frame.size() - 1, 1'b0});
        send_down(pay);
        while (exp_eth.size() != 0) @(posedge clk);
    endtask

    task automatic drain_down();
        while (exp_down.size() != 0) @(posedge clk);
    endtask

    always @(posedge clk) begin
        down_out_ready <= ready_gaps ? ($urandom_range(3) != 0) : 1'b1;
        eth_out_ready <= ready_gaps ? ($urandom_range(2) != 0) : 1'b1;
    end

    // Monitors
    always @(posedge clk) begin
        if (!rst && down_out_valid && down_out_ready)
            got_down.push_back({down_out_data, down_out_last, down_out_user});
        if (!rst && eth_out_valid && eth_out_ready)
            got_eth.push_back({eth_out_data, eth_out_last, eth_out_user});
    end

    // Comparator
    always @(posedge clk) begin
        logic [9:0] e;
        logic [9:0] g;
        while (got_down.size() != 0 && exp_down.size() != 0) begin
            e = exp_down.pop_front();
            g = got_down.pop_front();
            checks++;
            if (e != g) begin
                $display("FAIL %s: down_out data/last/user expected %h actual %h",
                         test_name, e, g);
                errors++;
            end
        end
        while (got_eth.size() != 0 && exp_eth.size() != 0) begin
            e = exp_eth.pop_front();
            g = got_eth.pop_front();
            checks++;
            if (e != g) begin
                $display("FAIL %s: eth_out data/last/user expected %h actual %h",
                         test_name, e, g);
                errors++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles during %s",
                 TIMEOUT_CYCLES, test_name);
        $display("Regression failed");
        $finish;
    end

    initial begin
        bq_t pay;
        void'($urandom(32'h66c90c95));
        rst = 1'b1;
        {eth_in_data, eth_in_valid, eth_in_last, eth_in_user} = '0;
        {down_in_data, down_in_valid, down_in_last, down_in_user} = '0;
        down_out_ready = 1'b1;
        eth_out_ready = 1'b1;
        local_mac = MY_MAC;
        local_ip = MY_IP;
        local_port = MY_PORT;
        ready_gaps = 1'b0;
        errors = 0;
        checks = 0;
        test_name = "reset";
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Both input readies high and both output valids low out of reset
        checks++;
        if (!eth_in_ready || !down_in_ready || eth_out_valid || down_out_valid) begin
            $display("FAIL %s: ready/valid expected 1100 actual %b%b%b%b", test_name,
                     eth_in_ready, down_in_ready, eth_out_valid, down_out_valid);
            errors++;
        end

        test_name = "match";
        good_request(MY_MAC, 48'h0a_11_22_33_44_55, 32'hc0a8_0105, 16'h4000,
                     1 + $urandom_range(59));
        good_request(48'hffff_ffff_ffff, 48'h0a_11_22_33_44_56, 32'hc0a8_0106, 16'h4001,
                     1 + $urandom_range(59));
        drain_down();

        test_name = "filter";
        pay = random_payload(12);
        send_eth(build_request(MY_MAC, 16'h0800, MY_IP, 16'h1235, 48'h0a_01, 32'h1, 16'h7,
                               pay, 16'd20, 0));
        send_eth(build_request(MY_MAC, 16'h86dd, MY_IP, MY_PORT, 48'h0a_01, 32'h1, 16'h7,
                               pay, 16'd20, 0));
        send_eth(build_request(MY_MAC, 16'h0800, 32'h0a00_0003, MY_PORT, 48'h0a_01, 32'h1,
                               16'h7, pay, 16'd20, 0));
        send_eth(build_request(48'h02_00_00_00_00_11, 16'h0800, MY_IP, MY_PORT, 48'h0a_01,
                               32'h1, 16'h7, pay, 16'd20, 0));
        good_request(MY_MAC, 48'h0a_11_22_33_44_57, 32'hc0a8_0107, 16'h4002, 7);
        drain_down();

        test_name = "padding";
        pay = random_payload(5);
        foreach (pay[i]) exp_down.push_back({pay[i], i == 4, 1'b0});
        send_eth(build_request(MY_MAC, 16'h0800, MY_IP, MY_PORT, 48'h0a_01, 32'h1, 16'h7,
                               pay, 16'd13, 13));
        drain_down();

        test_name = "truncated";
        pay = random_payload(10);
        foreach (pay[i]) exp_down.push_back({pay[i], i == 9, i == 9});
        send_eth(build_request(MY_MAC, 16'h0800, MY_IP, MY_PORT, 48'h0a_01, 32'h1, 16'h7,
                               pay, 16'd28, 0));
        drain_down();

        test_name = "reply";
        good_request(MY_MAC, 48'h0a_aa_bb_cc_dd_ee, 32'hc0a8_0142, 16'hd431,
                     1 + $urandom_range(59));
        drain_down();
        reply_check(48'h0a_aa_bb_cc_dd_ee, 32'hc0a8_0142, 16'hd431);

        test_name = "backpressure";
        ready_gaps = 1'b1;
        for (int k = 0; k < 3; k++) begin
            good_request(MY_MAC, 48'h0a_00_00_00_10_00 + k, 32'hc0a8_0200 + k, 16'h5000 + k,
                         1 + $urandom_range(59));
            drain_down();
            reply_check(48'h0a_00_00_00_10_00 + k, 32'hc0a8_0200 + k, 16'h5000 + k);
        end
        ready_gaps = 1'b0;

        // Idle time to catch stray bytes
        repeat (100) @(posedge clk);
        if (got_down.size() != 0 || got_eth.size() != 0) begin
            $display("Extra bytes came out that no test expected");
            errors++;
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* udp_ctrl_interface.f */
verilog/udp_ctrl_pkg.sv
verilog/udp_rx_parser.sv
verilog/skid_buffer.sv
verilog/reply_fifo.sv
verilog/udp_tx_framer.sv
verilog/udp_ctrl_interface.sv
bench/tb_udp_ctrl_interface.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the testbench with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_udp_ctrl_interface \
    -f udp_ctrl_interface.f -o sim_udp_ctrl > build.log 2>&1 \
    && ./obj_dir/sim_udp_ctrl > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Regression failed" sim.log \
    && { echo "Simulation reported failure, see sim.log"; exit 1; } \
    || { grep -q "Regression passed" sim.log || { echo "No result in sim.log"; exit 1; }; }
echo "Simulation passed"
